// ==== common/decodePkg.sv ====
package decodePkg;

  ////////////////////
  // Widths and sizes
  ////////////////////
  localparam int regWidth    = 16;  // Scalar register data width
  localparam int numRegs     = 16;
  localparam int regIdxWidth = 4;
  localparam int irWidth     = 32;  // Instruction word
  localparam int pcWidth     = 16;
  localparam int immWidth    = 16;  // Raw immediate in ir[15:0]

  ////////////////////
  // Instruction fields
  ////////////////////
  localparam int opcodeMsb = 31;
  localparam int opcodeLsb = 24;
  localparam int destMsb   = 23;    // STW data source as well
  localparam int destLsb   = 20;
  localparam int src1Msb   = 19;    // Destination of MOV and MOVI
  localparam int src1Lsb   = 16;
  localparam int src2Msb   = 11;
  localparam int src2Lsb   = 8;

  localparam int opcodeWidth = opcodeMsb - opcodeLsb + 1;

  ////////////////////
  // Condition code
  ////////////////////
  localparam int ccWidth = 3;
  localparam logic [ccWidth-1:0] ccNeg  = 3'b100;
  localparam logic [ccWidth-1:0] ccZero = 3'b010;
  localparam logic [ccWidth-1:0] ccPos  = 3'b001;

  // Upper opcode bits shared by all BR forms
  localparam logic [opcodeWidth-ccWidth-1:0] brPrefix = 5'b01000;

  // Branch encodings carry their n/z/p mask in the low three bits
  typedef enum logic [opcodeWidth-1:0] {
    opNop   = 8'h00,
    opAdd   = 8'h01,
    opAddi  = 8'h02,
    opAnd   = 8'h03,
    opAndi  = 8'h04,
    opMov   = 8'h05,
    opMovi  = 8'h06,
    opLdw   = 8'h07,
    opStw   = 8'h08,
    opBrn   = 8'h44,  // n
    opBrz   = 8'h42,  // z
    opBrp   = 8'h41,  // p
    opBrnz  = 8'h46,
    opBrnp  = 8'h45,
    opBrzp  = 8'h43,
    opBrnzp = 8'h47   // Always taken
  } opcodeE;

endpackage

// ==== decode/operandDecoder.sv ====
`timescale 1ns/1ps

module operandDecoder import decodePkg::*; (
  input  logic [irWidth-1:0]     ir,
  output opcodeE                 opcode,
  output logic [regIdxWidth-1:0] dest,      // Selected destination
  output logic [regIdxWidth-1:0] src1,
  output logic [regIdxWidth-1:0] src2,
  output logic [regWidth-1:0]    imm,
  output logic                   writesReg,
  output logic                   usesSrc1,
  output logic                   usesSrc2,
  output logic                   usesDest,  // STW store data
  output logic                   isBranch,
  output logic [ccWidth-1:0]     ccMask
);

  logic [opcodeWidth-1:0]     rawOp;
  logic signed [immWidth-1:0] rawImm;

  assign rawOp  = ir[opcodeMsb:opcodeLsb];
  assign rawImm = ir[immWidth-1:0];

  ////////////////////
  // Opcode classification
  ////////////////////
  always_comb begin
    case (rawOp)
      opAdd, opAddi, opAnd, opAndi, opMov, opMovi, opLdw, opStw,
      opBrn, opBrz, opBrp, opBrnz, opBrnp, opBrzp, opBrnzp: opcode = opcodeE'(rawOp);
      default: opcode = opNop;  // Anything unknown issues as a bubble
    endcase
  end

  // Which fields each instruction reads or writes
  always_comb begin
    writesReg = 1'b0;
    usesSrc1  = 1'b0;
    usesSrc2  = 1'b0;
    usesDest  = 1'b0;
    case (opcode)
      opAdd, opAnd: begin
        writesReg = 1'b1;
        usesSrc1  = 1'b1;
        usesSrc2  = 1'b1;
      end
      opAddi, opAndi, opLdw: begin
        writesReg = 1'b1;
        usesSrc1  = 1'b1;
      end
      opMov: begin
        writesReg = 1'b1;
        usesSrc2  = 1'b1;  // MOV copies the src2 register
      end
      opMovi: writesReg = 1'b1;
      opStw: begin
        usesSrc1 = 1'b1;  // Base address
        usesDest = 1'b1;  // Data to store
      end
      default: ;
    endcase
  end

  // MOV and MOVI put their target in the src1 field
  assign dest = (opcode == opMov || opcode == opMovi) ? ir[src1Msb:src1Lsb]
                                                      : ir[destMsb:destLsb];
  assign src1 = ir[src1Msb:src1Lsb];
  assign src2 = ir[src2Msb:src2Lsb];
  assign imm  = regWidth'(rawImm);  // Sign extension through the signed cast

  assign isBranch = (opcode[opcodeWidth-1:ccWidth] == brPrefix);
  assign ccMask   = isBranch ? opcode[ccWidth-1:0] : '0;

endmodule

// ==== decode/regFile.sv ====
`timescale 1ns/1ps

module regFile import decodePkg::*; (
  input  logic                   I_CLOCK,
  input  logic                   rstN,
  input  logic                   wbEnable,
  input  logic [regIdxWidth-1:0] wbIdx,
  input  logic [regWidth-1:0]    wbData,
  input  logic [regIdxWidth-1:0] rdIdx1,
  input  logic [regIdxWidth-1:0] rdIdx2,
  input  logic [regIdxWidth-1:0] rdIdx3,
  output logic [regWidth-1:0]    rdData1,
  output logic [regWidth-1:0]    rdData2,
  output logic [regWidth-1:0]    rdData3,   // STW data port
  output logic [ccWidth-1:0]     cc
);

  logic [regWidth-1:0] regs [numRegs];
  logic [ccWidth-1:0]  wbCc;  // Condition code of the value in flight

  // Read with same-cycle writeback bypass
  function automatic logic [regWidth-1:0] readPort(input logic [regIdxWidth-1:0] idx);
    if (wbEnable && wbIdx == idx) begin
      return wbData;
    end
    return regs[idx];
  endfunction

  ////////////////////
  // Read ports
  ////////////////////
  always_comb begin
    rdData1 = readPort(rdIdx1);
    rdData2 = readPort(rdIdx2);
    rdData3 = readPort(rdIdx3);
  end

  // Sign bit first, then nonzero
  always_comb begin
    if (wbData[regWidth-1]) begin
      wbCc = ccNeg;
    end else if (wbData != '0) begin
      wbCc = ccPos;
    end else begin
      wbCc = ccZero;
    end
  end

  ////////////////////
  // Writeback
  ////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
      cc <= ccZero;   // Registers all zero after reset
    end else if (wbEnable) begin
      regs[wbIdx] <= wbData;
      cc          <= wbCc;  // Every writeback updates cc
    end
  end

endmodule

// ==== decode/scoreboard.sv ====
`timescale 1ns/1ps

module scoreboard import decodePkg::*; (
  input  logic                   I_CLOCK,
  input  logic                   rstN,
  input  logic                   wbEnable,
  input  logic [regIdxWidth-1:0] wbIdx,
  input  logic [regIdxWidth-1:0] src1,
  input  logic [regIdxWidth-1:0] src2,
  input  logic [regIdxWidth-1:0] dest,
  input  logic                   usesSrc1,
  input  logic                   usesSrc2,
  input  logic                   usesDest,
  input  logic                   isBranch,
  input  logic                   instrValid,
  input  logic                   fetchStall,
  input  logic [regIdxWidth-1:0] setIdx,    // Register written by this instruction
  input  logic                   writesReg,
  output logic                   depStall,
  output logic                   branchStall
);

  logic [numRegs-1:0] pending;  // One bit per register, set until writeback
  logic               srcHazard;
  logic               branchHazard;
  logic               accept;

  // Source still owed by an older instruction
  // A writeback this cycle reaches the read through the bypass
  function automatic logic busy(input logic uses, input logic [regIdxWidth-1:0] idx);
    return uses && pending[idx] && !(wbEnable && wbIdx == idx);
  endfunction

  ////////////////////
  // Stall decision
  ////////////////////
  always_comb begin
    srcHazard = busy(usesSrc1, src1) || busy(usesSrc2, src2) || busy(usesDest, dest);
  end

  // cc only final once nothing is in flight
  assign branchHazard = isBranch && (|pending);

  assign depStall    = instrValid && (srcHazard || branchHazard);
  assign branchStall = instrValid && isBranch;   // Fetch holds while a branch decodes
  assign accept      = instrValid && !fetchStall && !depStall;

  ////////////////////
  // Pending bits
  ////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (!rstN) begin
      pending <= '0;
    end else begin
      for (int i = 0; i < numRegs; i++) begin
        // Set beats clear on the same register
        if (accept && writesReg && setIdx == regIdxWidth'(i)) begin
          pending[i] <= 1'b1;
        end else if (wbEnable && wbIdx == regIdxWidth'(i)) begin
          pending[i] <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== decode/issueRegister.sv ====
`timescale 1ns/1ps

module issueRegister import decodePkg::*; (
  input  logic                   I_CLOCK,
  input  logic                   rstN,
  input  logic                   instrValid,
  input  logic                   fetchStall,
  input  logic                   depStall,
  input  logic [pcWidth-1:0]     pc,
  input  opcodeE                 opcode,
  input  logic [regWidth-1:0]    rdData1,
  input  logic [regWidth-1:0]    rdData2,
  input  logic [regWidth-1:0]    rdData3,
  input  logic [regIdxWidth-1:0] setIdx,
  input  logic [regWidth-1:0]    imm,
  input  logic                   isBranch,
  input  logic [ccWidth-1:0]     ccMask,
  input  logic [ccWidth-1:0]     cc,
  output logic                   issueValid,
  output logic [pcWidth-1:0]     issuePc,
  output opcodeE                 issueOpcode,
  output logic [regWidth-1:0]    src1Value,
  output logic [regWidth-1:0]    src2Value,
  output logic [regWidth-1:0]    storeValue,
  output logic [regIdxWidth-1:0] destIdx,
  output logic [regWidth-1:0]    issueImm,
  output logic                   branchTaken
);

  logic accept;
  logic taken;

  assign accept = instrValid && !fetchStall && !depStall;

  // Taken when the n/z/p mask hits the current cc
  assign taken = isBranch && (|(ccMask & cc));

  ////////////////////
  // Control
  ////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (!rstN) begin
      issueValid  <= 1'b0;
      branchTaken <= 1'b0;
    end else begin
      issueValid <= accept;  // High for one cycle per accepted instruction
      if (accept) begin
        branchTaken <= taken;
      end
    end
  end

  ////////////////////
  // Payload, held when nothing is accepted
  ////////////////////
  always_ff @(posedge I_CLOCK) begin
    if (accept) begin
      issuePc     <= pc;
      issueOpcode <= opcode;
      src1Value   <= rdData1;
      src2Value   <= rdData2;
      storeValue  <= rdData3;  // Only meaningful for STW
      destIdx     <= setIdx;
      issueImm    <= imm;
    end
  end

endmodule

// ==== decode/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import decodePkg::*; (
  input  logic                   I_CLOCK,
  input  logic                   rstN,
  // Fetch side
  input  logic                   instrValid,
  input  logic [pcWidth-1:0]     pc,
  input  logic [irWidth-1:0]     ir,
  input  logic                   fetchStall,
  // Writeback side
  input  logic                   wbEnable,
  input  logic [regIdxWidth-1:0] wbIdx,
  input  logic [regWidth-1:0]    wbData,
  // Back to fetch
  output logic                   depStall,
  output logic                   branchStall,
  // Toward execute
  output logic                   issueValid,
  output logic [pcWidth-1:0]     issuePc,
  output opcodeE                 issueOpcode,
  output logic [regWidth-1:0]    src1Value,
  output logic [regWidth-1:0]    src2Value,
  output logic [regWidth-1:0]    storeValue,
  output logic [regIdxWidth-1:0] destIdx,
  output logic [regWidth-1:0]    imm,
  output logic                   branchTaken
);

  opcodeE                 opcode;
  logic [regIdxWidth-1:0] dest;
  logic [regIdxWidth-1:0] src1;
  logic [regIdxWidth-1:0] src2;
  logic [regWidth-1:0]    decImm;    // Sign-extended, not yet issued
  logic                   writesReg;
  logic                   usesSrc1;
  logic                   usesSrc2;
  logic                   usesDest;
  logic                   isBranch;
  logic [ccWidth-1:0]     ccMask;
  logic [regWidth-1:0]    rdData1;
  logic [regWidth-1:0]    rdData2;
  logic [regWidth-1:0]    rdData3;
  logic [ccWidth-1:0]     cc;

  ////////////////////
  // Input side
  ////////////////////
  operandDecoder dec0 (
    .ir(ir), .opcode(opcode), .dest(dest), .src1(src1), .src2(src2), .imm(decImm),
    .writesReg(writesReg), .usesSrc1(usesSrc1), .usesSrc2(usesSrc2),
    .usesDest(usesDest), .isBranch(isBranch), .ccMask(ccMask)
  );

  ////////////////////
  // Register state and hazards
  ////////////////////
  regFile rf0 (
    .I_CLOCK(I_CLOCK), .rstN(rstN), .wbEnable(wbEnable), .wbIdx(wbIdx), .wbData(wbData),
    .rdIdx1(src1), .rdIdx2(src2), .rdIdx3(dest),  // Port 3 reads STW data
    .rdData1(rdData1), .rdData2(rdData2), .rdData3(rdData3), .cc(cc)
  );

  scoreboard sb0 (
    .I_CLOCK(I_CLOCK), .rstN(rstN), .wbEnable(wbEnable), .wbIdx(wbIdx),
    .src1(src1), .src2(src2), .dest(dest),
    .usesSrc1(usesSrc1), .usesSrc2(usesSrc2), .usesDest(usesDest), .isBranch(isBranch),
    .instrValid(instrValid), .fetchStall(fetchStall), .setIdx(dest),
    .writesReg(writesReg), .depStall(depStall), .branchStall(branchStall)
  );

  ////////////////////
  // Output side
  ////////////////////
  issueRegister iss0 (
    .I_CLOCK(I_CLOCK), .rstN(rstN), .instrValid(instrValid), .fetchStall(fetchStall),
    .depStall(depStall), .pc(pc), .opcode(opcode),
    .rdData1(rdData1), .rdData2(rdData2), .rdData3(rdData3), .setIdx(dest),
    .imm(decImm), .isBranch(isBranch), .ccMask(ccMask), .cc(cc),
    .issueValid(issueValid), .issuePc(issuePc), .issueOpcode(issueOpcode),
    .src1Value(src1Value), .src2Value(src2Value), .storeValue(storeValue),
    .destIdx(destIdx), .issueImm(imm), .branchTaken(branchTaken)
  );

endmodule

// ==== dv/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
  output logic I_CLOCK,
  output logic rstN
);

  localparam int halfPeriod  = 4;   // 8 ns period
  localparam int resetCycles = 16;

  initial begin
    I_CLOCK = 1'b0;
    forever #(halfPeriod) I_CLOCK = ~I_CLOCK;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge I_CLOCK);
    rstN <= 1'b1;
  end

endmodule

// ==== dv/decodeTb.sv ====
`timescale 1ns/1ps

module decodeTb import decodePkg::*; ();

  localparam int randIters      = 200;
  localparam int iterCycles     = 6;    // One writeback plus one ADD
  localparam int directedCycles = 300;
  localparam int watchdogCycles = directedCycles + randIters * iterCycles + 500;

  logic                   I_CLOCK;
  logic                   rstN;
  logic                   instrValid;
  logic [pcWidth-1:0]     pc;
  logic [irWidth-1:0]     ir;
  logic                   fetchStall;
  logic                   wbEnable;
  logic [regIdxWidth-1:0] wbIdx;
  logic [regWidth-1:0]    wbData;
  logic                   depStall;
  logic                   branchStall;
  logic                   issueValid;
  logic [pcWidth-1:0]     issuePc;
  opcodeE                 issueOpcode;
  logic [regWidth-1:0]    src1Value;
  logic [regWidth-1:0]    src2Value;
  logic [regWidth-1:0]    storeValue;
  logic [regIdxWidth-1:0] destIdx;
  logic [regWidth-1:0]    imm;
  logic                   branchTaken;

  // Reference model of the architectural state
  logic [regWidth-1:0] modelRegs [numRegs];
  logic [numRegs-1:0]  modelPending;
  logic [ccWidth-1:0]  modelCc;
  integer              seed;

  tbClock clk0 (.I_CLOCK(I_CLOCK), .rstN(rstN));

  decodeStage dut0 (
    .I_CLOCK(I_CLOCK), .rstN(rstN), .instrValid(instrValid), .pc(pc), .ir(ir),
    .fetchStall(fetchStall), .wbEnable(wbEnable), .wbIdx(wbIdx), .wbData(wbData),
    .depStall(depStall), .branchStall(branchStall), .issueValid(issueValid),
    .issuePc(issuePc), .issueOpcode(issueOpcode), .src1Value(src1Value),
    .src2Value(src2Value), .storeValue(storeValue), .destIdx(destIdx), .imm(imm),
    .branchTaken(branchTaken)
  );

  ////////////////////
  // Model helpers
  ////////////////////
  function automatic logic [irWidth-1:0] encode(input logic [7:0] op, input logic [3:0] d,
                                                input logic [3:0] s1, input logic [15:0] low);
    return {op, d, s1, low};
  endfunction

  // Register form with src2 in bits 11 to 8
  function automatic logic [irWidth-1:0] regOp(input logic [7:0] op, input logic [3:0] d,
                                               input logic [3:0] s1, input logic [3:0] s2);
    return encode(op, d, s1, {4'h0, s2, 8'h00});
  endfunction

  function automatic logic writesRegOp(input logic [7:0] op);
    return op inside {opAdd, opAddi, opAnd, opAndi, opMov, opMovi, opLdw};
  endfunction

  function automatic logic isBranchOp(input logic [7:0] op);
    return op[7:3] == 5'b01000;
  endfunction

  function automatic logic [3:0] destOf(input logic [irWidth-1:0] irV);
    if (irV[31:24] == opMov || irV[31:24] == opMovi) begin
      return irV[19:16];   // MOV forms name the target in src1
    end
    return irV[23:20];
  endfunction

  function automatic logic [ccWidth-1:0] ccOf(input logic [regWidth-1:0] value);
    if (value[regWidth-1]) begin
      return ccNeg;
    end
    if (value != '0) begin
      return ccPos;
    end
    return ccZero;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic applyWriteback(input logic [3:0] idx, input logic [regWidth-1:0] data);
    modelRegs[idx]    = data;
    modelCc           = ccOf(data);
    modelPending[idx] = 1'b0;
  endtask

  ////////////////////
  // Bus drivers
  ////////////////////
  task automatic writeBack(input logic [3:0] idx, input logic [regWidth-1:0] data);
    @(posedge I_CLOCK);
    wbEnable <= 1'b1;
    wbIdx    <= idx;
    wbData   <= data;
    @(posedge I_CLOCK);
    wbEnable <= 1'b0;
    applyWriteback(idx, data);   // Written on this edge
  endtask

  // Present one instruction, wait out any stall, check the issued fields
  task automatic issueInstr(input logic [pcWidth-1:0] pcV, input logic [irWidth-1:0] irV);
    logic [7:0] op;
    logic       expTaken;
    op = irV[31:24];
    @(posedge I_CLOCK);
    instrValid <= 1'b1;
    pc         <= pcV;
    ir         <= irV;
    @(negedge I_CLOCK);
    checkValue("branchStall", branchStall, isBranchOp(op));
    while (depStall) begin
      @(negedge I_CLOCK);    // Fetch holds the instruction during the stall
    end
    expTaken = isBranchOp(op) && (|(op[2:0] & modelCc));
    @(posedge I_CLOCK);
    instrValid <= 1'b0;
    if (writesRegOp(op)) begin
      modelPending[destOf(irV)] = 1'b1;
    end
    @(negedge I_CLOCK);
    checkValue("issueValid", issueValid, 1);
    checkValue("issuePc", issuePc, pcV);
    checkValue("issueOpcode", issueOpcode, op);
    checkValue("imm", imm, irV[15:0]);   // Immediate already at full width
    checkValue("branchTaken", branchTaken, expTaken);
    if (writesRegOp(op)) begin
      checkValue("destIdx", destIdx, destOf(irV));
    end
    @(negedge I_CLOCK);
    checkValue("issueValid", issueValid, 0);   // One cycle only
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic testReset();
    wait (rstN === 1'b1);
    @(negedge I_CLOCK);
    checkValue("issueValid", issueValid, 0);
    checkValue("branchTaken", branchTaken, 0);
    // Fetch holds both instructions back
    @(posedge I_CLOCK);
    instrValid <= 1'b1;
    fetchStall <= 1'b1;
    ir         <= regOp(opAdd, 4'd0, 4'd1, 4'd2);
    @(negedge I_CLOCK);
    checkValue("depStall", depStall, 0);
    checkValue("branchStall", branchStall, 0);
    @(posedge I_CLOCK);
    ir <= encode(opBrnzp, 4'd0, 4'd0, 16'h0000);
    @(negedge I_CLOCK);
    checkValue("issueValid", issueValid, 0);   // ADD not accepted
    checkValue("depStall", depStall, 0);       // No register pending
    checkValue("branchStall", branchStall, 1);
    @(posedge I_CLOCK);
    instrValid <= 1'b0;
    fetchStall <= 1'b0;
    @(negedge I_CLOCK);
    checkValue("issueValid", issueValid, 0);
  endtask

  task automatic testWriteRead();
    writeBack(4'd1, 16'h1234);
    writeBack(4'd2, 16'h8001);
    writeBack(4'd3, 16'h00ff);
    writeBack(4'd4, 16'h7777);
    issueInstr(16'h0100, regOp(opAdd, 4'd5, 4'd1, 4'd2));
    checkValue("src1Value", src1Value, modelRegs[1]);
    checkValue("src2Value", src2Value, modelRegs[2]);
    writeBack(4'd5, modelRegs[1] + modelRegs[2]);
    issueInstr(16'h0104, encode(opAddi, 4'd6, 4'd3, 16'hfff0));
    checkValue("src1Value", src1Value, modelRegs[3]);
    checkValue("imm", imm, 16'hfff0);   // Negative immediate
    writeBack(4'd6, 16'h00ef);
    issueInstr(16'h0108, encode(opStw, 4'd4, 4'd1, 16'h0010));
    checkValue("src1Value", src1Value, modelRegs[1]);
    checkValue("storeValue", storeValue, modelRegs[4]);
    issueInstr(16'h010c, regOp(opMov, 4'd9, 4'd7, 4'd3));
    checkValue("destIdx", destIdx, 7);
    checkValue("src2Value", src2Value, modelRegs[3]);
    writeBack(4'd7, modelRegs[3]);
    issueInstr(16'h0110, encode(opMovi, 4'd9, 4'd8, 16'h0042));
    checkValue("destIdx", destIdx, 8);
    writeBack(4'd8, 16'h0042);
  endtask

  task automatic testDepStall();
    issueInstr(16'h0200, regOp(opAdd, 4'd2, 4'd1, 4'd1));   // r2 now pending
    @(posedge I_CLOCK);
    instrValid <= 1'b1;
    pc         <= 16'h0204;
    ir         <= regOp(opAnd, 4'd3, 4'd2, 4'd4);
    repeat (4) begin
      @(negedge I_CLOCK);
      checkValue("depStall", depStall, 1);
      checkValue("issueValid", issueValid, 0);
    end
    @(posedge I_CLOCK);
    wbEnable <= 1'b1;
    wbIdx    <= 4'd2;
    wbData   <= 16'h5a5a;
    @(negedge I_CLOCK);
    checkValue("depStall", depStall, 0);   // Bypass releases the AND
    @(posedge I_CLOCK);
    instrValid <= 1'b0;
    wbEnable   <= 1'b0;
    applyWriteback(4'd2, 16'h5a5a);
    modelPending[3] = 1'b1;
    @(negedge I_CLOCK);
    checkValue("issueValid", issueValid, 1);
    checkValue("issueOpcode", issueOpcode, opAnd);
    checkValue("src1Value", src1Value, 16'h5a5a);
    checkValue("src2Value", src2Value, modelRegs[4]);
    checkValue("destIdx", destIdx, 3);
    writeBack(4'd3, 16'h5a5a & modelRegs[4]);
  endtask

  task automatic testBranches();
    logic [regWidth-1:0] values [3] = '{16'hf00d, 16'h0000, 16'h0123};
    for (int v = 0; v < 3; v++) begin
      writeBack(4'd9, values[v]);   // Sets cc to n, z, then p
      for (int m = 1; m < 8; m++) begin
        issueInstr(16'h0300 + 16'(m), encode({5'b01000, 3'(m)}, 4'd0, 4'd0, 16'h0000));
      end
    end
  endtask

  task automatic testBranchWait();
    issueInstr(16'h0400, encode(opLdw, 4'd10, 4'd1, 16'h0004));
    @(posedge I_CLOCK);
    instrValid <= 1'b1;
    pc         <= 16'h0404;
    ir         <= encode(opBrz, 4'd0, 4'd0, 16'h0000);
    repeat (3) begin
      @(negedge I_CLOCK);
      checkValue("depStall", depStall, |modelPending);
      checkValue("branchStall", branchStall, 1);
      checkValue("issueValid", issueValid, 0);
    end
    @(posedge I_CLOCK);
    wbEnable <= 1'b1;
    wbIdx    <= 4'd10;
    wbData   <= 16'h0000;
    @(negedge I_CLOCK);
    checkValue("depStall", depStall, |modelPending);   // cc still old
    @(posedge I_CLOCK);
    wbEnable <= 1'b0;
    applyWriteback(4'd10, 16'h0000);
    @(negedge I_CLOCK);
    checkValue("depStall", depStall, |modelPending);
    @(posedge I_CLOCK);
    instrValid <= 1'b0;
    @(negedge I_CLOCK);
    checkValue("issueValid", issueValid, 1);
    checkValue("branchTaken", branchTaken, |(3'b010 & modelCc));
  endtask

  // Each ADD targets the register of the next writeback
  task automatic testRandom();
    logic [31:0]            rnd;
    logic [regIdxWidth-1:0] wIdx;
    logic [regIdxWidth-1:0] a;
    logic [regIdxWidth-1:0] b;
    rnd  = $random(seed);
    wIdx = rnd[3:0];
    for (int i = 0; i < randIters; i++) begin
      rnd = $random(seed);
      writeBack(wIdx, rnd[15:0]);
      rnd = $random(seed);
      a   = rnd[3:0];
      b   = rnd[7:4];
      wIdx = rnd[11:8];
      issueInstr(16'h1000 + 16'(i), regOp(opAdd, wIdx, a, b));
      checkValue("src1Value", src1Value, modelRegs[a]);
      checkValue("src2Value", src2Value, modelRegs[b]);
    end
    rnd = $random(seed);
    writeBack(wIdx, rnd[15:0]);   // Clear the last pending bit
  endtask

  ////////////////////
  // Sequence and watchdog
  ////////////////////
  initial begin
    seed       = 32'hb310;
    instrValid = 1'b0;
    pc         = '0;
    ir         = '0;
    fetchStall = 1'b0;
    wbEnable   = 1'b0;
    wbIdx      = '0;
    wbData     = '0;
    for (int i = 0; i < numRegs; i++) begin
      modelRegs[i] = '0;
    end
    modelPending = '0;
    modelCc      = ccZero;   // State after reset
    testReset();
    testWriteRead();
    testDepStall();
    testBranches();
    testBranchWait();
    testRandom();
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    repeat (watchdogCycles) @(posedge I_CLOCK);
    $display("Timeout: the decode tests did not finish within %0d cycles", watchdogCycles);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== list.f ====
common/decodePkg.sv
decode/operandDecoder.sv
decode/regFile.sv
decode/scoreboard.sv
decode/issueRegister.sv
decode/decodeStage.sv
dv/tbClock.sv
dv/decodeTb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - common/decodePkg.sv
  - decode/operandDecoder.sv
  - decode/regFile.sv
  - decode/scoreboard.sv
  - decode/issueRegister.sv
  - decode/decodeStage.sv
  - target: test
    files:
      - dv/tbClock.sv
      - dv/decodeTb.sv
